// File: design/gaussian_blur.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input must be whole ROI frames ending with a last beat
// Border outputs are zero and interior ones use 1 2 1 weights
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module gaussian_blur (
    input  logic                  clock,
    input  logic                  reset,
    input  lane_pkg::gray_beat_t  in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output lane_pkg::gray_beat_t  out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import lane_pkg::*;

    localparam int ROI_W = `LANE_ROI_WIDTH;
    localparam int ROI_H = `LANE_ROI_HEIGHT;

    blur_state_t state;
    roi_x_t      in_x;
    roi_x_t      fill_count;
    roi_x_t      out_x;
    roi_y_t      out_y;

    // Two rows of history indexed by column
    gray_t line_a [0:ROI_W-1];
    gray_t line_b [0:ROI_W-1];

    // Previous two window columns, top row first
    gray_t col_hist [0:1][0:2];
    gray_t window   [0:2][0:2];

    logic        can_load;
    logic        in_accept;
    logic        emit;
    logic        border;
    logic        final_out;
    logic [11:0] kernel_sum;

    assign can_load  = !out_valid || out_ready;
    assign in_ready  = (state != BLUR_FLUSH) && can_load;
    assign in_accept = in_valid && in_ready;

    // One output per input while running, then drain without input
    assign emit = ((state == BLUR_RUN) && in_accept)
               || ((state == BLUR_FLUSH) && can_load);

    assign border = (out_x == '0) || (out_x == roi_x_t'(ROI_W - 1))
                 || (out_y == '0) || (out_y == roi_y_t'(ROI_H - 1));
    assign final_out = (out_x == roi_x_t'(ROI_W - 1)) && (out_y == roi_y_t'(ROI_H - 1));

    // Newest column comes from the line buffers and the incoming pixel
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            window[r][0] = col_hist[0][r];
            window[r][1] = col_hist[1][r];
        end
        window[0][2] = line_b[in_x];
        window[1][2] = line_a[in_x];
        window[2][2] = in_beat.pixel;
    end

    // Corners weigh 1, edges 2 and the centre 4
    always_comb begin
        kernel_sum = 12'(window[0][0]) + 12'(window[0][2])
                   + 12'(window[2][0]) + 12'(window[2][2]);
        kernel_sum = kernel_sum
                   + (12'(window[0][1]) << 1) + (12'(window[1][0]) << 1)
                   + (12'(window[1][2]) << 1) + (12'(window[2][1]) << 1);
        kernel_sum = kernel_sum + (12'(window[1][1]) << 2);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= BLUR_FILL;
            in_x       <= '0;
            fill_count <= '0;
            out_x      <= '0;
            out_y      <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (emit) begin
                out_valid <= 1'b1;
                if (out_x == roi_x_t'(ROI_W - 1)) begin
                    out_x <= '0;
                    out_y <= final_out ? '0 : out_y + 1'b1;
                end else begin
                    out_x <= out_x + 1'b1;
                end
            end
            if (in_accept) begin
                if (in_beat.last || (in_x == roi_x_t'(ROI_W - 1))) begin
                    in_x <= '0;
                end else begin
                    in_x <= in_x + 1'b1;
                end
            end

            case (state)
                BLUR_FILL: begin
                    // One row plus one pixel before the first centre is complete
                    if (in_accept) begin
                        if (fill_count == roi_x_t'(ROI_W)) begin
                            fill_count <= '0;
                            state      <= BLUR_RUN;
                        end else begin
                            fill_count <= fill_count + 1'b1;
                        end
                    end
                end
                BLUR_RUN: begin
                    if (in_accept && in_beat.last) begin
                        state <= BLUR_FLUSH;
                    end
                end
                BLUR_FLUSH: begin
                    if (emit && final_out) begin
                        state <= BLUR_FILL;
                    end
                end
                default: state <= BLUR_FILL;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_accept) begin
            line_b[in_x] <= line_a[in_x];
            line_a[in_x] <= in_beat.pixel;
            for (int r = 0; r < 3; r++) begin
                col_hist[0][r] <= col_hist[1][r];
                col_hist[1][r] <= window[r][2];
            end
        end
        if (emit) begin
            out_beat.pixel <= border ? '0 : gray_t'(kernel_sum >> `LANE_BLUR_SHIFT);
            out_beat.last  <= final_out;
        end
    end

    // The output register is only loaded from RUN or FLUSH
    a_no_output_in_fill: assert property (@(posedge clock) disable iff (reset)
        $rose(out_valid) |-> $past(state) != BLUR_FILL);

endmodule

`default_nettype wire

// File: design/grayscale_converter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Plain channel average with truncation, no luma weights
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module grayscale_converter (
    input  logic                  clock,
    input  logic                  reset,
    input  lane_pkg::rgb_beat_t   in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output lane_pkg::gray_beat_t  out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import lane_pkg::*;

    logic [9:0] channel_sum;
    gray_t      average;
    logic       in_accept;

    assign in_ready  = !out_valid || out_ready;
    assign in_accept = in_valid && in_ready;

    // Three 8-bit channels need 10 bits before the divide
    assign channel_sum = 10'(in_beat.pixel[23:16])
                       + 10'(in_beat.pixel[15:8])
                       + 10'(in_beat.pixel[7:0]);
    assign average = gray_t'(channel_sum / 10'd3);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (in_accept) begin
                out_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_accept) begin
            out_beat.pixel <= average;
            out_beat.last  <= in_beat.last;
        end
    end

endmodule

`default_nettype wire

// File: design/lane_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Only the 16x12 frame with a 12x10 ROI is built and tested
// ROI bounds are inclusive and must lie inside the frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LANE_CONSTS_SVH
`define LANE_CONSTS_SVH

// Full frame in pixels
`define LANE_FRAME_WIDTH 16
`define LANE_FRAME_HEIGHT 12

// Region of interest around the road mask
`define LANE_ROI_START_X 2
`define LANE_ROI_END_X 13
`define LANE_ROI_START_Y 1
`define LANE_ROI_END_Y 10

`define LANE_ROI_WIDTH (`LANE_ROI_END_X - `LANE_ROI_START_X + 1)
`define LANE_ROI_HEIGHT (`LANE_ROI_END_Y - `LANE_ROI_START_Y + 1)

// Binomial weights sum to 16
`define LANE_BLUR_SHIFT 4

// Entries in each pixel FIFO
`define LANE_FIFO_DEPTH 8

`endif

// File: design/lane_front_end.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input is full 16x12 RGB frames in raster order
// Output is the blurred 12x10 ROI with last on its final pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module lane_front_end (
    input  logic                  clock,
    input  logic                  reset,
    input  lane_pkg::rgb_t        in_pixel,
    input  logic                  in_valid,
    output logic                  in_ready,
    output lane_pkg::gray_beat_t  out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import lane_pkg::*;

    // Input FIFO to cropper
    rgb_t       fifo_pixel;
    logic       fifo_valid;
    logic       fifo_ready;

    // Cropper to grayscale
    rgb_beat_t  crop_beat;
    logic       crop_valid;
    logic       crop_ready;

    // Grayscale to gray FIFO
    gray_beat_t gray_beat;
    logic       gray_valid;
    logic       gray_ready;

    // Gray FIFO to blur
    gray_beat_t blur_beat;
    logic       blur_valid;
    logic       blur_ready;

    pixel_fifo #(
        .DATA_WIDTH($bits(rgb_t)),
        .DEPTH     (`LANE_FIFO_DEPTH)
    ) rgb_fifo_inst (
        .clock    (clock),
        .reset    (reset),
        .in_data  (in_pixel),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (fifo_pixel),
        .out_valid(fifo_valid),
        .out_ready(fifo_ready)
    );

    roi_cropper cropper_inst (
        .clock    (clock),
        .reset    (reset),
        .in_pixel (fifo_pixel),
        .in_valid (fifo_valid),
        .in_ready (fifo_ready),
        .out_beat (crop_beat),
        .out_valid(crop_valid),
        .out_ready(crop_ready)
    );

    grayscale_converter gray_inst (
        .clock    (clock),
        .reset    (reset),
        .in_beat  (crop_beat),
        .in_valid (crop_valid),
        .in_ready (crop_ready),
        .out_beat (gray_beat),
        .out_valid(gray_valid),
        .out_ready(gray_ready)
    );

    pixel_fifo #(
        .DATA_WIDTH($bits(gray_beat_t)),
        .DEPTH     (`LANE_FIFO_DEPTH)
    ) gray_fifo_inst (
        .clock    (clock),
        .reset    (reset),
        .in_data  (gray_beat),
        .in_valid (gray_valid),
        .in_ready (gray_ready),
        .out_data (blur_beat),
        .out_valid(blur_valid),
        .out_ready(blur_ready)
    );

    gaussian_blur blur_inst (
        .clock    (clock),
        .reset    (reset),
        .in_beat  (blur_beat),
        .in_valid (blur_valid),
        .in_ready (blur_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// File: design/lane_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Coordinate widths fit the 16x12 frame only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lane_pkg;

    // Red in the top byte, blue in the bottom byte
    typedef logic [23:0] rgb_t;
    typedef logic [7:0] gray_t;

    typedef logic [4:0] frame_x_t;
    typedef logic [3:0] frame_y_t;
    typedef logic [3:0] roi_x_t;
    typedef logic [3:0] roi_y_t;

    typedef struct packed {
        rgb_t pixel;
        logic last;
    } rgb_beat_t;

    typedef struct packed {
        gray_t pixel;
        logic  last;
    } gray_beat_t;

    typedef enum logic [1:0] {
        BLUR_FILL,
        BLUR_RUN,
        BLUR_FLUSH
    } blur_state_t;

endpackage

`default_nettype wire

// File: design/pixel_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single clock, DEPTH of 2 or more
// out_data shows the head entry whenever out_valid is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_write;
    logic                  do_read;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count alone
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Full and not drained means nothing new can land
    a_no_write_full: assert property (@(posedge clock) disable iff (reset)
        (count == CNT_W'(DEPTH)) && !do_read |=> $stable(wr_ptr));

    // Empty FIFO never advances its read side
    a_no_read_empty: assert property (@(posedge clock) disable iff (reset)
        (count == '0) |=> $stable(rd_ptr));

endmodule

`default_nettype wire

// File: design/roi_cropper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expects whole frames in raster order
// A partial frame leaves the position counters out of step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module roi_cropper (
    input  logic                 clock,
    input  logic                 reset,
    input  lane_pkg::rgb_t       in_pixel,
    input  logic                 in_valid,
    output logic                 in_ready,
    output lane_pkg::rgb_beat_t  out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import lane_pkg::*;

    frame_x_t frame_x;
    frame_y_t frame_y;
    logic     in_accept;
    logic     in_roi;
    logic     roi_last;
    logic     frame_x_end;
    logic     frame_y_end;

    // Output register free or emptied this cycle
    assign in_ready  = !out_valid || out_ready;
    assign in_accept = in_valid && in_ready;

    assign frame_x_end = (frame_x == frame_x_t'(`LANE_FRAME_WIDTH - 1));
    assign frame_y_end = (frame_y == frame_y_t'(`LANE_FRAME_HEIGHT - 1));

    assign in_roi = (frame_x >= frame_x_t'(`LANE_ROI_START_X))
                 && (frame_x <= frame_x_t'(`LANE_ROI_END_X))
                 && (frame_y >= frame_y_t'(`LANE_ROI_START_Y))
                 && (frame_y <= frame_y_t'(`LANE_ROI_END_Y));

    // Bottom right corner of the ROI closes the frame downstream
    assign roi_last = (frame_x == frame_x_t'(`LANE_ROI_END_X))
                   && (frame_y == frame_y_t'(`LANE_ROI_END_Y));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frame_x   <= '0;
            frame_y   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (in_accept) begin
                if (in_roi) begin
                    out_valid <= 1'b1;
                end
                if (frame_x_end) begin
                    frame_x <= '0;
                    frame_y <= frame_y_end ? '0 : frame_y + 1'b1;
                end else begin
                    frame_x <= frame_x + 1'b1;
                end
            end
        end
    end

    // Pixels outside the ROI are consumed and dropped here
    always_ff @(posedge clock) begin
        if (in_accept && in_roi) begin
            out_beat.pixel <= in_pixel;
            out_beat.last  <= roi_last;
        end
    end

    a_position_in_frame: assert property (@(posedge clock) disable iff (reset)
        in_accept |=> (frame_x < frame_x_t'(`LANE_FRAME_WIDTH))
                   && (frame_y < frame_y_t'(`LANE_FRAME_HEIGHT)));

endmodule

`default_nettype wire

// File: lane_front_end.f
+incdir+design
design/lane_pkg.sv
design/pixel_fifo.sv
design/roi_cropper.sv
design/grayscale_converter.sv
design/gaussian_blur.sv
design/lane_front_end.sv
tests/clock_gen.sv
tests/lane_front_end_tb.sv

// File: tests/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free running 8 ns clock
// Reset is high for the first 3 rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);
    localparam realtime HALF_PERIOD = 4.0;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Release lands just after an edge so no flop sees it mid-sample
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/lane_front_end_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests on whole 16x12 frames with a reference model
// Stops at the first wrong beat or after 4000 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "lane_consts.svh"

module lane_front_end_tb;
    import lane_pkg::*;

    localparam int FRAME_PIXELS   = `LANE_FRAME_WIDTH * `LANE_FRAME_HEIGHT;
    localparam int ROI_PIXELS     = `LANE_ROI_WIDTH * `LANE_ROI_HEIGHT;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LCG_SEED = 32'd73571;

    logic       clock;
    logic       reset;
    rgb_t       in_pixel;
    logic       in_valid;
    logic       in_ready;
    gray_beat_t out_beat;
    logic       out_valid;
    logic       out_ready;

    rgb_t        frame_pix [0:FRAME_PIXELS-1];
    gray_beat_t  expected_q [$];
    gray_beat_t  expected_beat;
    logic [31:0] pixel_seed;
    logic [31:0] ready_seed;
    logic        ready_random;
    int          cycle_count = 0;
    int          beat_count  = 0;
    int          last_count  = 0;
    int          beat_base;
    int          last_base;

    clock_gen clock_gen_inst (
        .clock(clock),
        .reset(reset)
    );

    lane_front_end DUT (
        .clock    (clock),
        .reset    (reset),
        .in_pixel (in_pixel),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic gray_t channel_average(input rgb_t p);
        return gray_t'((int'(p[23:16]) + int'(p[15:8]) + int'(p[7:0])) / 3);
    endfunction

    function automatic int kernel_weight(input int r, input int c);
        return (r == 1 ? 2 : 1) * (c == 1 ? 2 : 1);
    endfunction

    function automatic logic on_border(input int x, input int y);
        return (x == 0) || (x == `LANE_ROI_WIDTH - 1)
            || (y == 0) || (y == `LANE_ROI_HEIGHT - 1);
    endfunction

    // Crop, average and blur the frame in frame_pix into the expected queue
    function automatic void push_model_frame();
        gray_t      roi [0:`LANE_ROI_HEIGHT-1][0:`LANE_ROI_WIDTH-1];
        gray_beat_t beat;
        int         sum;
        for (int y = 0; y < `LANE_ROI_HEIGHT; y++) begin
            for (int x = 0; x < `LANE_ROI_WIDTH; x++) begin
                roi[y][x] = channel_average(frame_pix[(y + `LANE_ROI_START_Y) *
                    `LANE_FRAME_WIDTH + x + `LANE_ROI_START_X]);
            end
        end
        for (int y = 0; y < `LANE_ROI_HEIGHT; y++) begin
            for (int x = 0; x < `LANE_ROI_WIDTH; x++) begin
                sum = 0;
                if (!on_border(x, y)) begin
                    for (int r = 0; r < 3; r++) begin
                        for (int c = 0; c < 3; c++) begin
                            sum += kernel_weight(r, c) * int'(roi[y + r - 1][x + c - 1]);
                        end
                    end
                end
                beat.pixel = gray_t'(sum >> `LANE_BLUR_SHIFT);
                beat.last  = (x == `LANE_ROI_WIDTH - 1) && (y == `LANE_ROI_HEIGHT - 1);
                expected_q.push_back(beat);
            end
        end
    endfunction

    // A flat frame blurs to its own level inside and zero on the border
    function automatic void expect_flat_frame(input gray_t level);
        gray_beat_t beat;
        for (int y = 0; y < `LANE_ROI_HEIGHT; y++) begin
            for (int x = 0; x < `LANE_ROI_WIDTH; x++) begin
                beat.pixel = on_border(x, y) ? '0 : level;
                beat.last  = (x == `LANE_ROI_WIDTH - 1) && (y == `LANE_ROI_HEIGHT - 1);
                expected_q.push_back(beat);
            end
        end
    endfunction

    function automatic void fill_random_frame();
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            pixel_seed   = lcg_next(pixel_seed);
            frame_pix[i] = pixel_seed[31:8];
        end
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
            abort_run();
        end
    endtask

    // Optional idle cycles before each pixel when with_gaps is set
    task automatic send_frame(input logic with_gaps);
        logic [1:0] gap;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            if (with_gaps) begin
                pixel_seed = lcg_next(pixel_seed);
                gap = pixel_seed[17:16];
                repeat (gap) begin
                    in_valid <= 1'b0;
                    @(posedge clock);
                end
            end
            in_pixel <= frame_pix[i];
            in_valid <= 1'b1;
            @(posedge clock);
            while (!in_ready) @(posedge clock);
        end
        in_valid <= 1'b0;
    endtask

    task automatic start_test(input string name);
        $display("Running %s", name);
        beat_base = beat_count;
        last_base = last_count;
    endtask

    // Idle cycles after the drain catch any extra or repeated beat
    task automatic end_test(input int beats, input int lasts);
        while (expected_q.size() != 0) @(posedge clock);
        repeat (20) @(posedge clock);
        check_value("out_beat count", beat_count - beat_base, beats);
        check_value("out_beat.last count", last_count - last_base, lasts);
    endtask

    task automatic single_random_frame();
        start_test("random frame");
        fill_random_frame();
        push_model_frame();
        send_frame(1'b0);
        end_test(ROI_PIXELS, 1);
    endtask

    task automatic flat_colour_frame();
        start_test("flat colour frame");
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            frame_pix[i] = 24'h50A0F0;
        end
        expect_flat_frame(channel_average(24'h50A0F0));
        send_frame(1'b0);
        end_test(ROI_PIXELS, 1);
    endtask

    task automatic random_back_pressure();
        start_test("random output back-pressure");
        fill_random_frame();
        push_model_frame();
        ready_random <= 1'b1;
        send_frame(1'b0);
        end_test(ROI_PIXELS, 1);
        ready_random <= 1'b0;
    endtask

    task automatic input_valid_gaps();
        start_test("input valid gaps");
        fill_random_frame();
        push_model_frame();
        send_frame(1'b1);
        end_test(ROI_PIXELS, 1);
    endtask

    task automatic back_to_back_frames();
        start_test("two frames back to back");
        fill_random_frame();
        push_model_frame();
        send_frame(1'b0);
        fill_random_frame();
        push_model_frame();
        send_frame(1'b0);
        end_test(2 * ROI_PIXELS, 2);
    endtask

    always @(posedge clock) begin
        if (ready_random) begin
            ready_seed = lcg_next(ready_seed);
            out_ready <= ready_seed[16];
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clock) begin
        if (!reset && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("Output beat arrived with no expected beat left to match it");
                abort_run();
            end else begin
                expected_beat = expected_q.pop_front();
                check_value("out_beat.pixel", out_beat.pixel, expected_beat.pixel);
                check_value("out_beat.last", out_beat.last, expected_beat.last);
                beat_count++;
                if (out_beat.last) begin
                    last_count++;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d beats still expected",
                     cycle_count, expected_q.size());
            abort_run();
        end
    end

    initial begin
        in_pixel     = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        ready_random = 1'b0;
        pixel_seed   = LCG_SEED;
        ready_seed   = LCG_SEED;
        @(negedge reset);
        @(posedge clock);
        // Input side open and output idle straight out of reset
        check_value("in_ready", in_ready, 1);
        check_value("out_valid", out_valid, 0);
        single_random_frame();
        flat_colour_frame();
        random_back_pressure();
        input_valid_gaps();
        back_to_back_frames();
        if (expected_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Expected beats were left over at the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire
